// ==== design/emem_pkg.sv ====
package emem_pkg;

   // Mesh data and address widths
   localparam int DW = 32;
   localparam int AW = 32;

   // Memory is 64 bits wide and addressed by word
   localparam int MAW       = 16;
   localparam int MEM_WORDS = 1 << MAW;

   // Access size carried in every mesh packet
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,
      DM_SHORT  = 2'b01,
      DM_WORD   = 2'b10,
      DM_DOUBLE = 2'b11
   } datamode_e;

   // Mesh packet, 104 bits
   // For doubles srcaddr carries the upper 32 data bits
   typedef struct packed {
      logic [AW-1:0] srcaddr;
      logic [DW-1:0] data;
      logic [AW-1:0] dstaddr;
      logic [4:0]    ctrlmode;
      datamode_e     datamode;
      logic          write;
   } emesh_packet_t;

   // Two 32-bit halves of a memory word
   typedef struct packed {
      logic [DW-1:0] hi;
      logic [DW-1:0] lo;
   } mem_half_t;

   // One memory word, seen as byte lanes or as two halves
   // Lane 0 is the least significant byte
   typedef union packed {
      logic [7:0][7:0] bytes;
      mem_half_t       half;
   } mem_word_u;

   // What a read needs to remember until its reply goes out
   typedef struct packed {
      datamode_e     datamode;
      logic [4:0]    ctrlmode;
      logic [2:0]    align;
      logic [AW-1:0] retaddr;
   } reply_ctx_t;

endpackage

// ==== design/emem_write_path.sv ====
`timescale 1ns/1ps

module emem_write_path (
   input  emem_pkg::emesh_packet_t   packet,
   output logic [emem_pkg::MAW-1:0]  addr,
   output emem_pkg::mem_word_u       din,
   output logic [7:0]                wen
);
   import emem_pkg::*;

   logic [2:0] lane;
   logic [7:0] size_mask;

   // Byte offset inside the 64-bit word
   assign lane = packet.dstaddr[2:0];

   // Drop the byte offset to get the word address
   assign addr = packet.dstaddr[MAW+2:3];

   // Replicate narrow data into every lane it could land in,
   // the mask then picks the lanes that are actually written
   always_comb
   begin
      case (packet.datamode)
         DM_BYTE:
         begin
            din.bytes = {8{packet.data[7:0]}};
         end
         DM_SHORT:
         begin
            din.bytes = {4{packet.data[15:0]}};
         end
         DM_WORD:
         begin
            din.bytes = {2{packet.data}};
         end
         default:
         begin
            // Double, upper half comes from srcaddr
            din.half = '{hi: packet.srcaddr, lo: packet.data};
         end
      endcase
   end

   // Lanes touched by an access of this size at this offset
   always_comb
   begin
      case (packet.datamode)
         DM_BYTE:
         begin
            size_mask = 8'b0000_0001 << lane;
         end
         DM_SHORT:
         begin
            // Pair 2k, 2k+1
            size_mask = 8'b0000_0011 << {lane[2:1], 1'b0};
         end
         DM_WORD:
         begin
            size_mask = lane[2] ? 8'b1111_0000 : 8'b0000_1111;
         end
         default:
         begin
            size_mask = 8'b1111_1111;
         end
      endcase
   end

   // Read requests leave the array untouched
   assign wen = packet.write ? size_mask : 8'h00;

endmodule

// ==== design/emem_sram.sv ====
`timescale 1ns/1ps

module emem_sram (
   input  logic                      clk,
   input  logic                      en,
   input  logic [7:0]                wen,
   input  logic [emem_pkg::MAW-1:0]  addr,
   input  emem_pkg::mem_word_u       din,
   output emem_pkg::mem_word_u       dout
);
   import emem_pkg::*;

   mem_word_u mem [MEM_WORDS];
   mem_word_u rd_word;

   // Word as it stands after this access
   // Written lanes bypass the array
   always_comb
   begin
      for (int i = 0; i < 8; i++)
      begin
         rd_word.bytes[i] = wen[i] ? din.bytes[i] : mem[addr].bytes[i];
      end
   end

   // Byte-masked write and registered read on enabled edges
   always_ff @(posedge clk)
   begin
      if (en)
      begin
         for (int i = 0; i < 8; i++)
         begin
            if (wen[i])
            begin
               mem[addr].bytes[i] <= din.bytes[i];
            end
         end
         dout <= rd_word;
      end
   end

endmodule

// ==== design/emem_read_align.sv ====
`timescale 1ns/1ps

module emem_read_align (
   input  emem_pkg::mem_word_u      dout,
   input  emem_pkg::reply_ctx_t     ctx,
   output emem_pkg::emesh_packet_t  packet
);
   import emem_pkg::*;

   logic [7:0]    sel_byte;
   logic [15:0]   sel_short;
   logic [DW-1:0] sel_word;
   logic [DW-1:0] data;
   logic [AW-1:0] upper;

   // Candidate lanes for each size
   assign sel_byte = dout.bytes[ctx.align];

   // Short lane pair chosen by align bits 2 and 1
   assign sel_short = {dout.bytes[{ctx.align[2:1], 1'b1}],
                       dout.bytes[{ctx.align[2:1], 1'b0}]};

   assign sel_word = ctx.align[2] ? dout.half.hi : dout.half.lo;

   // Shift down to bit 0 and zero-extend
   always_comb
   begin
      case (ctx.datamode)
         DM_BYTE:
         begin
            data = {{(DW-8){1'b0}}, sel_byte};
         end
         DM_SHORT:
         begin
            data = {{(DW-16){1'b0}}, sel_short};
         end
         DM_WORD:
         begin
            data = sel_word;
         end
         default:
         begin
            data = dout.half.lo;
         end
      endcase
   end

   // Upper half rides in srcaddr, only for doubles
   assign upper = (ctx.datamode == DM_DOUBLE) ? dout.half.hi : '0;

   // Reply goes back as a write to the requester
   always_comb
   begin
      packet.srcaddr  = upper;
      packet.data     = data;
      packet.dstaddr  = ctx.retaddr;
      packet.ctrlmode = ctx.ctrlmode;
      packet.datamode = ctx.datamode;
      packet.write    = 1'b1;
   end

endmodule

// ==== design/ememory.sv ====
`timescale 1ns/1ps

module ememory (
   input  logic                     clk,
   input  logic                     nreset,
   input  logic                     access_in,
   input  emem_pkg::emesh_packet_t  packet_in,
   input  logic                     wait_in,
   output logic                     wait_out,
   output logic                     access_out,
   output emem_pkg::emesh_packet_t  packet_out
);
   import emem_pkg::*;

   logic           accept;
   logic           rd_accept;
   logic [MAW-1:0] addr;
   mem_word_u      din;
   mem_word_u      dout;
   logic [7:0]     wen;
   reply_ctx_t     ctx;

   // Mesh back-pressure passes straight through
   assign wait_out = wait_in;

   // Packet is taken only while the mesh is not stalling
   assign accept    = access_in & ~wait_in;
   assign rd_accept = accept & ~packet_in.write;

   // Address, lane data and byte mask from the request
   emem_write_path u_write_path (
      .packet (packet_in),
      .addr   (addr),
      .din    (din),
      .wen    (wen)
   );

   // Reads also use en, with an all-zero mask
   emem_sram u_sram (
      .clk  (clk),
      .en   (accept),
      .wen  (wen),
      .addr (addr),
      .din  (din),
      .dout (dout)
   );

   // Reply strobe, one cycle after an accepted read
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         access_out <= 1'b0;
      end
      else
      begin
         access_out <= rd_accept;
      end
   end

   // Request context lines up with the registered read word
   always_ff @(posedge clk)
   begin
      ctx.datamode <= packet_in.datamode;
      ctx.ctrlmode <= packet_in.ctrlmode;
      ctx.align    <= packet_in.dstaddr[2:0];
      ctx.retaddr  <= packet_in.srcaddr;
   end

   // Build the reply packet from the read word
   emem_read_align u_read_align (
      .dout   (dout),
      .ctx    (ctx),
      .packet (packet_out)
   );

endmodule

// ==== bench/emem_checker.sv ====
`timescale 1ns/1ps

module emem_checker (
   input  logic                     clk,
   input  logic                     nreset,
   input  logic                     access_in,
   input  emem_pkg::emesh_packet_t  packet_in,
   input  logic                     wait_in,
   input  logic                     wait_out,
   input  logic                     access_out,
   input  emem_pkg::emesh_packet_t  packet_out,
   output int                       checks,
   output int                       value_errors,
   output int                       reply_errors,
   output logic                     busy
);
   import emem_pkg::*;

   // Byte model covering every address bit the memory decodes
   localparam int MODEL_BYTES = 1 << (MAW + 3);

   logic [7:0]    model [MODEL_BYTES];
   emesh_packet_t expected_q [$];
   emesh_packet_t exp_pkt;

   initial
   begin
      checks       = 0;
      value_errors = 0;
      reply_errors = 0;
      busy         = 1'b0;
   end

   // Lowest byte address of an access, aligned to its size
   function automatic logic [18:0] base_addr(input emesh_packet_t p);
      logic [18:0] mask;
      mask      = 19'((1 << p.datamode) - 1);
      base_addr = p.dstaddr[18:0] & ~mask;
   endfunction

   // Bytes 0 to 3 from data, 4 to 7 from srcaddr
   task automatic apply_write(input emesh_packet_t p);
      logic [63:0] val;
      logic [18:0] base;
      val  = {p.srcaddr, p.data};
      base = base_addr(p);
      for (int i = 0; i < (1 << p.datamode); i++)
      begin
         model[base + i] = val[8*i +: 8];
      end
   endtask

   function automatic emesh_packet_t expect_reply(input emesh_packet_t p);
      logic [63:0] val;
      logic [18:0] base;
      val  = '0;
      base = base_addr(p);
      for (int i = 0; i < (1 << p.datamode); i++)
      begin
         val[8*i +: 8] = model[base + i];
      end
      expect_reply.srcaddr  = (p.datamode == DM_DOUBLE) ? val[63:32] : 32'h0;
      expect_reply.data     = val[31:0];
      expect_reply.dstaddr  = p.srcaddr;
      expect_reply.ctrlmode = p.ctrlmode;
      expect_reply.datamode = p.datamode;
      expect_reply.write    = 1'b1;
   endfunction

   task automatic compare_field(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      checks++;
      if (act !== exp)
      begin
         value_errors++;
         $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   // Inputs and outputs are both settled at the falling edge
   always @(negedge clk)
   begin
      compare_field("wait_out", {31'b0, wait_in}, {31'b0, wait_out});
      if (!nreset)
      begin
         if (access_out !== 1'b0)
         begin
            reply_errors++;
            $display("At %0t the reply strobe is high during reset", $time);
         end
         expected_q.delete();
      end
      else
      begin
         if (expected_q.size() > 0)
         begin
            exp_pkt = expected_q.pop_front();
            if (access_out !== 1'b1)
            begin
               reply_errors++;
               $display("At %0t no reply came for the read accepted a cycle before", $time);
            end
            else
            begin
               compare_field("packet_out.srcaddr", exp_pkt.srcaddr, packet_out.srcaddr);
               compare_field("packet_out.data", exp_pkt.data, packet_out.data);
               compare_field("packet_out.dstaddr", exp_pkt.dstaddr, packet_out.dstaddr);
               compare_field("packet_out.ctrlmode", 32'(exp_pkt.ctrlmode),
                             32'(packet_out.ctrlmode));
               compare_field("packet_out.datamode", 32'(exp_pkt.datamode),
                             32'(packet_out.datamode));
               compare_field("packet_out.write", 32'(exp_pkt.write), 32'(packet_out.write));
            end
         end
         else if (access_out !== 1'b0)
         begin
            reply_errors++;
            $display("At %0t a reply came out with no read accepted before it", $time);
         end
         // Request taken on the coming rising edge
         if (access_in && !wait_in)
         begin
            if (packet_in.write)
            begin
               apply_write(packet_in);
            end
            else
            begin
               expected_q.push_back(expect_reply(packet_in));
            end
         end
      end
      busy = (expected_q.size() > 0);
   end

endmodule

// ==== bench/ememory_tb.sv ====
`timescale 1ns/1ps

module ememory_tb;
   import emem_pkg::*;

   localparam int          TIMEOUT   = 2000;
   localparam int          WIN_WORDS = 64;
   localparam int          NUM_OPS   = 400;
   localparam logic [31:0] WIN_BASE  = 32'h0001_2000;

   logic          clk;
   logic          nreset;
   logic          access_in;
   logic          wait_in;
   logic          wait_out;
   logic          access_out;
   emesh_packet_t packet_in;
   emesh_packet_t packet_out;
   int            checks;
   int            value_errors;
   int            reply_errors;
   int            timeouts;
   logic          busy;
   logic [31:0]   lfsr;

   ememory uut (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   emem_checker check (
      .clk          (clk),
      .nreset       (nreset),
      .access_in    (access_in),
      .packet_in    (packet_in),
      .wait_in      (wait_in),
      .wait_out     (wait_out),
      .access_out   (access_out),
      .packet_out   (packet_out),
      .checks       (checks),
      .value_errors (value_errors),
      .reply_errors (reply_errors),
      .busy         (busy)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // Random size, aligned offset inside the test window
   task automatic random_packet(input logic wr, output emesh_packet_t p);
      logic [31:0] r;
      logic [1:0]  dm;
      logic [5:0]  word;
      logic [2:0]  lane;
      take_bits(2, r);
      dm = r[1:0];
      take_bits(6, r);
      word = r[5:0];
      take_bits(3, r);
      lane = r[2:0] & (3'b111 << dm);
      p.datamode = datamode_e'(dm);
      p.dstaddr  = WIN_BASE + {word, lane};
      take_bits(5, r);
      p.ctrlmode = r[4:0];
      take_bits(32, r);
      p.srcaddr = r;
      take_bits(32, r);
      p.data  = r;
      p.write = wr;
   endtask

   // Entered and left 1 ns after a rising edge
   task automatic issue(input emesh_packet_t pkt);
      logic [31:0] r;
      int          stall;
      int          n;
      take_bits(3, r);
      stall     = (r > 5) ? r - 5 : 0;
      packet_in = pkt;
      access_in = 1'b1;
      wait_in   = (stall > 0);
      n         = 0;
      // Sender holds the packet while the mesh stalls
      while (stall > 0 && n < TIMEOUT)
      begin
         @(posedge clk);
         #1;
         n++;
         stall--;
         wait_in = (stall > 0);
      end
      if (stall > 0)
      begin
         timeouts++;
         $display("Timeout: request still stalled after %0d cycles", n);
      end
      @(posedge clk);
      #1;
      access_in = 1'b0;
      take_bits(1, r);
      wait_in = r[0];
   endtask

   task automatic drain;
      int n;
      n = 0;
      while (busy && n < TIMEOUT)
      begin
         @(posedge clk);
         n++;
      end
      if (busy)
      begin
         timeouts++;
         $display("Timeout: a read reply is still outstanding at the end of the run");
      end
      repeat (2) @(posedge clk);
   endtask

   initial
   begin
      logic [31:0]   r;
      emesh_packet_t p;
      lfsr      = 32'habb2_c2b7;
      timeouts  = 0;
      nreset    = 1'b0;
      access_in = 1'b0;
      wait_in   = 1'b0;
      packet_in = '0;
      repeat (3) @(posedge clk);
      #1;
      nreset = 1'b1;

      // Fill every window word with a double
      for (int w = 0; w < WIN_WORDS && timeouts == 0; w++)
      begin
         random_packet(1'b1, p);
         p.datamode = DM_DOUBLE;
         p.dstaddr  = WIN_BASE + w * 8;
         issue(p);
      end

      // Read straight after a write to the same address
      for (int i = 0; i < 16 && timeouts == 0; i++)
      begin
         random_packet(1'b1, p);
         issue(p);
         p.write = 1'b0;
         take_bits(32, r);
         p.srcaddr = r;
         issue(p);
      end

      for (int i = 0; i < NUM_OPS && timeouts == 0; i++)
      begin
         take_bits(1, r);
         random_packet(r[0], p);
         issue(p);
         take_bits(3, r);
         if (r > 5)
         begin
            repeat (r - 5) @(posedge clk);
            #1;
         end
      end

      drain();
      $display("Checks %0d, value errors %0d, reply errors %0d, timeouts %0d",
               checks, value_errors, reply_errors, timeouts);
      if (value_errors == 0 && reply_errors == 0 && timeouts == 0)
      begin
         $display("Result: PASSED");
      end
      else
      begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
design/emem_pkg.sv
design/emem_write_path.sv
design/emem_sram.sv
design/emem_read_align.sv
design/ememory.sv
bench/emem_checker.sv
bench/ememory_tb.sv
